/* files.f */
+incdir+common
common/encoderPkg.sv
common/stepIf.sv
source/frameGate.sv
sequencer/stepSequencer.sv
sequencer/unitDispatcher.sv
source/encoderControl.sv
dv/clockGen.sv
dv/encoderChecker.sv
dv/encoderControl_properties.sv
dv/encoderControlTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = encoderControlTb
FILELIST = files.f
OBJDIR = obj_dir
RUNFLAGS = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

/* dv/encoderControlTb.sv */
`timescale 1ns/1ps

`include "encoder_defines.svh"

module encoderControlTb;

	import encoderPkg::*;

	logic clock;
	logic reset;
	logic start;
	logic abort;
	logic frameDone;
	unitMask_t unitDone = '0;
	unitMask_t unitStart;
	stepCode_t mathMuxSel;
	logic encodeDone;

	int startCount;
	int doneCount;
	int mismatchCount;
	int checkErrors = 0;
	int testsFailed = 0;
	int errorBase;
	int startBase;
	int doneBase;

	logic [31:0] lcgState = 32'd5293;
	int busyCycles = 0; // Cycles until the pending unit answers
	int startsSeen = 0;
	int holdIndex = -1; // Start that gets the long delay
	unitMask_t pendingMask = '0;

	clockGen clk0 (.clock(clock));

	encoderControl dut0
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.abort(abort),
		.frameDone(frameDone),
		.unitDone(unitDone),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.encodeDone(encodeDone)
	);

	encoderChecker check0
	(
		.clock(clock),
		.reset(reset),
		.abort(abort),
		.unitStart(unitStart),
		.mathMuxSel(mathMuxSel),
		.encodeDone(encodeDone),
		.startCount(startCount),
		.doneCount(doneCount),
		.mismatchCount(mismatchCount)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	//////////////////////////////////////////////////
	// Unit responders
	//////////////////////////////////////////////////

	always @(posedge clock)
	begin
		#2;
		unitDone = '0;
		if (busyCycles > 0)
		begin
			busyCycles = busyCycles - 1;
			if (busyCycles == 0)
				unitDone = pendingMask; // Single-cycle done
		end
		if (unitStart != '0)
		begin
			startsSeen = startsSeen + 1;
			pendingMask = unitStart;
			lcgState = lcgNext(lcgState);
			if (startsSeen == holdIndex)
				busyCycles = 30;
			else
				busyCycles = int'(lcgState[18:16]) + 1; // 1 to 8 cycles
		end
	end

	task automatic tick();
		@(posedge clock);
		#2;
	endtask

	task automatic reportError(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		checkErrors++;
	endtask

	task automatic timeoutFail(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic pulseFrame();
		frameDone = 1'b1;
		tick();
		frameDone = 1'b0;
	endtask

	// Returns once the monitor has counted the next encodeDone pulse
	task automatic waitEncodeDone(input int limit);
		int cycles;
		int target;
		cycles = 0;
		target = doneCount + 1;
		while (doneCount < target && cycles < limit)
		begin
			tick();
			cycles++;
		end
		if (doneCount < target)
			timeoutFail("encodeDone");
	endtask

	task automatic waitFirstStart(input int limit);
		int cycles;
		cycles = 0;
		do
		begin
			tick();
			cycles++;
		end
		while (unitStart == '0 && cycles < limit);
		if (unitStart == '0)
			timeoutFail("a unitStart pulse");
	endtask

	task automatic waitStartCount(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (startCount < target && cycles < limit)
		begin
			tick();
			cycles++;
		end
		if (startCount < target)
			timeoutFail("the unit start count");
	endtask

	// No activity allowed, optionally with the select at zero
	task automatic quietWindow(input int cycles, input logic selZero);
		int i;
		for (i = 0; i < cycles; i++)
		begin
			tick();
			if (unitStart != '0)
				reportError($sformatf("unexpected unitStart %h", unitStart));
			if (encodeDone)
				reportError("unexpected encodeDone");
			if (selZero && mathMuxSel != '0)
				reportError($sformatf("mathMuxSel %0d, expected 0", mathMuxSel));
		end
	endtask

	task automatic holdWindow(input int cycles);
		stepCode_t held;
		int i;
		held = mathMuxSel;
		for (i = 0; i < cycles; i++)
		begin
			tick();
			if (unitStart != '0)
				reportError("unitStart while a unit is stalled");
			if (mathMuxSel != held)
				reportError($sformatf("mathMuxSel %0d, expected held %0d", mathMuxSel, held));
		end
	endtask

	task automatic openTest();
		errorBase = checkErrors + mismatchCount;
		startBase = startCount;
		doneBase = doneCount;
	endtask

	task automatic expectCounts(input int starts, input int dones);
		if (startCount - startBase != starts)
			reportError($sformatf("%0d unit starts, expected %0d", startCount - startBase, starts));
		if (doneCount - doneBase != dones)
			reportError($sformatf("%0d encodeDone pulses, expected %0d", doneCount - doneBase, dones));
	endtask

	task automatic closeTest(input int num, input string name);
		int errors;
		errors = checkErrors + mismatchCount - errorBase;
		if (errors == 0)
			$display("Test %0d %s: passed", num, name);
		else
		begin
			$display("Test %0d %s: %0d errors", num, name, errors);
			testsFailed++;
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		abort = 1'b0;
		frameDone = 1'b0;
		repeat (16)
			@(posedge clock);
		#2;
		reset = 1'b0;

		openTest();
		pulseFrame();
		tick();
		pulseFrame(); // Gate still idle
		quietWindow(20, 1'b1);
		expectCounts(0, 0);
		closeTest(1, "idle before start");

		openTest();
		start = 1'b1;
		tick();
		start = 1'b0;
		pulseFrame();
		tick();
		pulseFrame();
		waitEncodeDone(1000);
		expectCounts(23, 1);
		closeTest(2, "full pass");

		openTest();
		pulseFrame();
		quietWindow(30, 1'b0);
		pulseFrame();
		waitEncodeDone(1000);
		expectCounts(23, 1);
		closeTest(3, "single pulse");

		openTest();
		holdIndex = startsSeen + 1;
		pulseFrame();
		tick();
		pulseFrame();
		waitFirstStart(50);
		holdWindow(29);
		waitEncodeDone(1000);
		expectCounts(23, 1);
		closeTest(4, "back-pressure");

		openTest();
		pulseFrame();
		tick();
		pulseFrame();
		waitStartCount(startBase + 12, 500); // Inside subframe 0
		abort = 1'b1;
		tick();
		abort = 1'b0;
		quietWindow(40, 1'b0);
		expectCounts(12, 0);
		pulseFrame();
		tick();
		pulseFrame();
		waitEncodeDone(1000);
		expectCounts(35, 1);
		closeTest(5, "abort");

		openTest();
		pulseFrame();
		tick();
		pulseFrame();
		waitFirstStart(50);
		repeat (4)
		begin
			pulseFrame(); // Third and fourth make a token, the rest are dropped
			tick();
			tick();
			tick();
		end
		waitEncodeDone(1000);
		waitEncodeDone(1000);
		quietWindow(60, 1'b0);
		expectCounts(46, 2);
		closeTest(6, "pending token");

		$display("Summary: 6 tests, %0d failed, %0d unit starts, %0d passes, %0d errors",
			testsFailed, startCount, doneCount,
			checkErrors + mismatchCount + dut0.props0.assertFails);
		if (testsFailed == 0 && dut0.props0.assertFails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* dv/encoderControl_properties.sv */
`timescale 1ns/1ps

module encoderControlProperties
(
	input logic clock,
	input logic reset,
	input logic abort,
	input encoderPkg::unitMask_t unitStart,
	input encoderPkg::unitMask_t unitDone,
	input encoderPkg::stepCode_t mathMuxSel,
	input logic encodeDone
);

	import encoderPkg::*;

	unitMask_t busyMask; // Unit started and not yet done
	int assertFails = 0;

	always_ff @(posedge clock)
	begin
		if (reset || abort)
			busyMask <= '0;
		else if (unitStart != '0)
			busyMask <= unitStart;
		else if ((unitDone & busyMask) != '0)
			busyMask <= '0;
	end

	//////////////////////////////////////////////////
	// Output protocol
	//////////////////////////////////////////////////

	// One unit at a time, and only once the previous one is done
	startOneHot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(unitStart) && (unitStart == '0 || busyMask == '0))
	else
	begin
		assertFails++;
		$error("unitStart not one-hot or given while a unit was busy");
	end

	selectHeld: assert property (@(posedge clock) disable iff (reset)
		(busyMask != '0) |-> $stable(mathMuxSel))
	else
	begin
		assertFails++;
		$error("mathMuxSel changed while a unit was busy");
	end

	donePulse: assert property (@(posedge clock) disable iff (reset)
		encodeDone |=> !encodeDone)
	else
	begin
		assertFails++;
		$error("encodeDone held longer than one cycle");
	end

endmodule

bind encoderControl encoderControlProperties props0
(
	.clock(clock),
	.reset(reset),
	.abort(abort),
	.unitStart(unitStart),
	.unitDone(unitDone),
	.mathMuxSel(mathMuxSel),
	.encodeDone(encodeDone)
);

/* dv/encoderChecker.sv */
`timescale 1ns/1ps

`include "encoder_defines.svh"

module encoderChecker
(
	input logic clock,
	input logic reset,
	input logic abort,
	input encoderPkg::unitMask_t unitStart,
	input encoderPkg::stepCode_t mathMuxSel,
	input logic encodeDone,
	output int startCount,
	output int doneCount,
	output int mismatchCount
);

	import encoderPkg::*;

	int position; // Steps seen in the current pass
	int code;
	unitMask_t expectedMask;

	//////////////////////////////////////////////////
	// Reference step order
	//////////////////////////////////////////////////

	// Code of the step at a pass position, -1 past the end
	function automatic int expectedCode(input int pos);
		int seen;
		int sub;
		int step;
		seen = 0;
		for (step = 0; step < 8; step++)
		begin
			if (seen == pos)
				return step;
			seen++;
		end
		for (sub = 0; sub < `NUM_SUBFRAMES; sub++)
		begin
			for (step = 8; step < 16; step++)
			begin
				if (step != 11 || sub == `PARITY_SUBFRAME)
				begin
					if (seen == pos)
						return step;
					seen++;
				end
			end
		end
		return -1;
	endfunction

	function automatic int passLength();
		int count;
		count = 0;
		while (expectedCode(count) >= 0)
			count++;
		return count;
	endfunction

	function automatic int unitForCode(input int stepCode);
		case (stepCode)
			0: return `UNIT_AUTOCORR;
			1: return `UNIT_LAG;
			2: return `UNIT_LEVINSON;
			3: return `UNIT_AZ;
			4: return `UNIT_QUA_LSP;
			5, 6, 8: return `UNIT_WEIGHT_AZ; // Two frame passes and one per subframe
			7: return `UNIT_PITCH_OL;
			9: return `UNIT_SYN_FILT;
			10: return `UNIT_PITCH_FR3;
			11: return `UNIT_PARITY_PITCH;
			12: return `UNIT_PRED_LT3;
			13: return `UNIT_G_PITCH;
			14: return `UNIT_ACELP;
			default: return `UNIT_QUA_GAIN;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Monitor, sampled mid cycle
	//////////////////////////////////////////////////

	always @(negedge clock)
	begin
		if (reset)
		begin
			position = 0;
			startCount = 0;
			doneCount = 0;
			mismatchCount = 0;
		end
		else
		begin
			if (unitStart != '0)
			begin
				startCount++;
				code = expectedCode(position);
				if (code < 0)
				begin
					mismatchCount++;
					$display("FAILED at %0t: unitStart %h past the end of the pass",
						$time, unitStart);
				end
				else
				begin
					expectedMask = unitMask_t'(1) << unitForCode(code);
					if (unitStart != expectedMask)
					begin
						mismatchCount++;
						$display("FAILED at %0t: step %0d unitStart %h, expected %h",
							$time, position, unitStart, expectedMask);
					end
					if (mathMuxSel != stepCode_t'(code))
					begin
						mismatchCount++;
						$display("FAILED at %0t: step %0d mathMuxSel %0d, expected %0d",
							$time, position, mathMuxSel, code);
					end
				end
				position++;
			end
			if (encodeDone)
			begin
				doneCount++;
				if (position != passLength())
				begin
					mismatchCount++;
					$display("FAILED at %0t: encodeDone after %0d steps, expected %0d",
						$time, position, passLength());
				end
				position = 0;
			end
			if (abort)
				position = 0; // Next pass starts over
		end
	end

endmodule

/* dv/clockGen.sv */
`timescale 1ns/1ps

module clockGen
(
	output logic clock
);

	localparam int halfPeriod = 20; // 40 ns period

	initial
	begin
		clock = 1'b0;
		forever
			#halfPeriod clock = ~clock;
	end

endmodule

/* source/encoderControl.sv */
`timescale 1ns/1ps

module encoderControl
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic abort, // Division error
	input logic frameDone,
	input encoderPkg::unitMask_t unitDone,
	output encoderPkg::unitMask_t unitStart,
	output encoderPkg::stepCode_t mathMuxSel,
	output logic encodeDone
);

	logic frameValid;
	logic frameReady;

	stepIf steps();

	frameGate gate0
	(
		.clock(clock),
		.reset(reset),
		.start(start),
		.frameDone(frameDone),
		.frameValid(frameValid),
		.frameReady(frameReady)
	);

	stepSequencer seq0
	(
		.clock(clock),
		.reset(reset),
		.abort(abort),
		.frameValid(frameValid),
		.frameReady(frameReady),
		.steps(steps.sequencer),
		.encodeDone(encodeDone)
	);

	unitDispatcher disp0
	(
		.clock(clock),
		.reset(reset),
		.abort(abort),
		.steps(steps.dispatcher),
		.unitStart(unitStart),
		.unitDone(unitDone),
		.mathMuxSel(mathMuxSel)
	);

endmodule

/* sequencer/unitDispatcher.sv */
`timescale 1ns/1ps

module unitDispatcher
(
	input logic clock,
	input logic reset,
	input logic abort,
	stepIf.dispatcher steps,
	output encoderPkg::unitMask_t unitStart,
	input encoderPkg::unitMask_t unitDone,
	output encoderPkg::stepCode_t mathMuxSel
);

	import encoderPkg::*;

	dispState_t state;
	unitId_t activeUnit; // Unit of the step in flight
	logic accept;

	assign accept = steps.stepValid && steps.stepReady;

	//////////////////////////////////////////////////
	// Dispatch state machine
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= DISP_READY;
			mathMuxSel <= '0;
		end
		else if (abort)
			state <= DISP_READY;
		else
		begin
			case (state)
				DISP_READY:
				begin
					if (accept)
					begin
						state <= DISP_START;
						mathMuxSel <= steps.stepCode; // Held for the whole step
					end
				end
				DISP_START:
					state <= DISP_BUSY;
				DISP_BUSY:
				begin
					if (unitDone[activeUnit])
						state <= DISP_READY;
				end
				default:
					state <= DISP_READY;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			activeUnit <= steps.unitId;
	end

	//////////////////////////////////////////////////
	// Unit handshake
	//////////////////////////////////////////////////

	// One start bit for a single cycle
	assign unitStart = (state == DISP_START) ? (unitMask_t'(1) << activeUnit) : '0;

	assign steps.stepReady = (state == DISP_READY);
	assign steps.stepDone = (state == DISP_BUSY) && unitDone[activeUnit]; // Only the matching bit

endmodule

/* sequencer/stepSequencer.sv */
`timescale 1ns/1ps

`include "encoder_defines.svh"

module stepSequencer
(
	input logic clock,
	input logic reset,
	input logic abort,
	input logic frameValid,
	output logic frameReady,
	stepIf.sequencer steps,
	output logic encodeDone
);

	import encoderPkg::*;

	localparam int stepCount = 16; // Frame steps then subframe steps
	localparam int indexWidth = $clog2(stepCount);
	localparam int subWidth = $clog2(`NUM_SUBFRAMES);
	localparam logic [indexWidth-1:0] firstSubStep = 8;
	localparam logic [indexWidth-1:0] parityStep = 11;
	localparam logic [indexWidth-1:0] lastTableStep = indexWidth'(stepCount - 1);
	localparam logic [subWidth-1:0] lastSubframe = subWidth'(`NUM_SUBFRAMES - 1);
	localparam logic [subWidth-1:0] paritySubframe = subWidth'(`PARITY_SUBFRAME);

	seqState_t state;
	logic [indexWidth-1:0] stepIndex;
	logic [indexWidth-1:0] nextIndex;
	logic [subWidth-1:0] subframe;
	unitId_t tableUnit;
	logic lastStep;

	//////////////////////////////////////////////////
	// Step table, code is the table position
	//////////////////////////////////////////////////

	always_comb
	begin
		case (stepIndex)
			4'd0: tableUnit = unitId_t'(`UNIT_AUTOCORR);
			4'd1: tableUnit = unitId_t'(`UNIT_LAG);
			4'd2: tableUnit = unitId_t'(`UNIT_LEVINSON);
			4'd3: tableUnit = unitId_t'(`UNIT_AZ);
			4'd4: tableUnit = unitId_t'(`UNIT_QUA_LSP);
			4'd5: tableUnit = unitId_t'(`UNIT_WEIGHT_AZ); // First weighting pass
			4'd6: tableUnit = unitId_t'(`UNIT_WEIGHT_AZ); // Second weighting pass
			4'd7: tableUnit = unitId_t'(`UNIT_PITCH_OL);
			4'd8: tableUnit = unitId_t'(`UNIT_WEIGHT_AZ); // Subframe starts here
			4'd9: tableUnit = unitId_t'(`UNIT_SYN_FILT);
			4'd10: tableUnit = unitId_t'(`UNIT_PITCH_FR3);
			4'd11: tableUnit = unitId_t'(`UNIT_PARITY_PITCH);
			4'd12: tableUnit = unitId_t'(`UNIT_PRED_LT3);
			4'd13: tableUnit = unitId_t'(`UNIT_G_PITCH);
			4'd14: tableUnit = unitId_t'(`UNIT_ACELP);
			default: tableUnit = unitId_t'(`UNIT_QUA_GAIN); // Step 15
		endcase
	end

	always_comb
	begin
		nextIndex = stepIndex + 1'b1;
		if (nextIndex == parityStep && subframe != paritySubframe)
			nextIndex = parityStep + 1'b1; // No parity pitch in this subframe
	end

	assign lastStep = (stepIndex == lastTableStep) && (subframe == lastSubframe);

	//////////////////////////////////////////////////
	// Pass control
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			stepIndex <= '0;
			subframe <= '0;
		end
		else if (abort)
			state <= SEQ_IDLE; // Division error drops the pass
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					if (frameValid && frameReady)
					begin
						state <= SEQ_ISSUE;
						stepIndex <= '0;
						subframe <= '0;
					end
				end
				SEQ_ISSUE:
				begin
					if (steps.stepReady)
						state <= SEQ_WAIT;
				end
				SEQ_WAIT:
				begin
					if (steps.stepDone)
					begin
						if (lastStep)
							state <= SEQ_FINISH;
						else if (stepIndex == lastTableStep)
						begin
							subframe <= subframe + 1'b1; // Next subframe
							stepIndex <= firstSubStep;
							state <= SEQ_ISSUE;
						end
						else
						begin
							stepIndex <= nextIndex;
							state <= SEQ_ISSUE;
						end
					end
				end
				default:
					state <= SEQ_IDLE; // After SEQ_FINISH
			endcase
		end
	end

	assign frameReady = (state == SEQ_IDLE);
	assign encodeDone = (state == SEQ_FINISH);
	assign steps.stepValid = (state == SEQ_ISSUE);
	assign steps.stepCode = stepCode_t'(stepIndex);
	assign steps.unitId = tableUnit;

endmodule

/* source/frameGate.sv */
`timescale 1ns/1ps

`include "encoder_defines.svh"

module frameGate
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic frameDone,
	output logic frameValid,
	input logic frameReady
);

	import encoderPkg::*;

	localparam int countWidth = $clog2(`FRAMES_PER_TOKEN + 1);
	localparam logic [countWidth-1:0] lastPulse = countWidth'(`FRAMES_PER_TOKEN - 1);

	gateState_t state;
	logic [countWidth-1:0] pulseCount; // Pulses toward the next token

	//////////////////////////////////////////////////
	// Pulse counting and token hold
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= GATE_IDLE;
			pulseCount <= '0;
			frameValid <= 1'b0;
		end
		else
		begin
			case (state)
				GATE_IDLE:
				begin
					if (start)
					begin
						state <= GATE_COUNT;
						pulseCount <= '0;
					end
				end
				GATE_COUNT:
				begin
					if (frameValid)
					begin
						// Token pending, pulses here are dropped
						if (frameReady)
							frameValid <= 1'b0; // Taken by the sequencer
					end
					else if (frameDone)
					begin
						if (pulseCount == lastPulse)
						begin
							frameValid <= 1'b1; // Offer a token
							pulseCount <= '0;
						end
						else
							pulseCount <= pulseCount + 1'b1;
					end
				end
				default:
					state <= GATE_IDLE;
			endcase
		end
	end

endmodule

/* common/stepIf.sv */
`timescale 1ns/1ps

interface stepIf;

	import encoderPkg::*;

	logic stepValid;
	stepCode_t stepCode;
	unitId_t unitId;
	logic stepReady;
	logic stepDone; // One cycle when the unit finishes

	modport sequencer
	(
		output stepValid, stepCode, unitId,
		input stepReady, stepDone
	);

	modport dispatcher
	(
		input stepValid, stepCode, unitId,
		output stepReady, stepDone
	);

endinterface

/* common/encoderPkg.sv */
package encoderPkg;

	`include "encoder_defines.svh"

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	// Code driven onto the shared math-bus select
	typedef logic [`STEP_WIDTH-1:0] stepCode_t;

	typedef logic [$clog2(`NUM_UNITS)-1:0] unitId_t; // Unit number

	typedef logic [`NUM_UNITS-1:0] unitMask_t; // One bit per unit

	//////////////////////////////////////////////////
	// State machines
	//////////////////////////////////////////////////

	// Frame gate, waiting for start or counting pulses
	typedef enum logic [0:0]
	{
		GATE_IDLE,
		GATE_COUNT
	} gateState_t;

	typedef enum logic [1:0]
	{
		SEQ_IDLE,   // Waiting for a frame token
		SEQ_ISSUE,  // Step offered to the dispatcher
		SEQ_WAIT,   // Step in flight
		SEQ_FINISH  // Pass complete
	} seqState_t;

	typedef enum logic [1:0]
	{
		DISP_READY, // Free for a step
		DISP_START, // Start pulse cycle
		DISP_BUSY   // Waiting on the unit
	} dispState_t;

endpackage

/* common/encoder_defines.svh */
`ifndef ENCODER_DEFINES_SVH
`define ENCODER_DEFINES_SVH

//////////////////////////////////////////////////
// Frame grouping and subframe structure
//////////////////////////////////////////////////

`define FRAMES_PER_TOKEN 2 // Frame pulses per token
`define NUM_SUBFRAMES 2
`define PARITY_SUBFRAME 0 // Only this subframe runs parity pitch

//////////////////////////////////////////////////
// Processing units
//////////////////////////////////////////////////

`define NUM_UNITS 14
`define STEP_WIDTH 6 // Width of the math-bus select

`define UNIT_AUTOCORR 0
`define UNIT_LAG 1 // Lag windowing
`define UNIT_LEVINSON 2
`define UNIT_AZ 3
`define UNIT_QUA_LSP 4
`define UNIT_WEIGHT_AZ 5
`define UNIT_PITCH_OL 6 // Open-loop pitch
`define UNIT_SYN_FILT 7
`define UNIT_PITCH_FR3 8 // Fractional pitch
`define UNIT_PARITY_PITCH 9
`define UNIT_PRED_LT3 10 // Long-term prediction
`define UNIT_G_PITCH 11
`define UNIT_ACELP 12 // Algebraic codebook
`define UNIT_QUA_GAIN 13

`endif
